// File: bench/tb_checks.svh
// Reference byte memory of the L2 and the typed compare tasks of the testbench
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ------------------------------------------------------------
// Reference memory
// ------------------------------------------------------------
localparam int WORDS = 1 << l2_pkg::WORD_ADDR_W;

logic [7:0] ref_mem [0:WORDS*8-1];

// Start-up contents, built from every bit of the word address
function automatic logic [l2_pkg::DATA_W-1:0] fill_word(input logic [14:0] idx);
   return {idx, ~idx, idx, ~idx, 4'h5};
endfunction

function automatic logic [l2_pkg::DATA_W-1:0] ref_word(input logic [14:0] w);
   logic [l2_pkg::DATA_W-1:0] r;
   for (int i = 0; i < 8; i++)
      r[i*8 +: 8] = ref_mem[{w, 3'(i)}];
   return r;
endfunction

// Merge the enabled bytes only
task automatic ref_write(input logic [14:0] w, input logic [63:0] data, input logic [7:0] be);
   for (int i = 0; i < 8; i++)
      if (be[i])
         ref_mem[{w, 3'(i)}] = data[i*8 +: 8];
endtask

task automatic ref_init();
   logic [63:0] v;
   for (int idx = 0; idx < WORDS; idx++)
   begin
      v = fill_word(15'(idx));
      for (int i = 0; i < 8; i++)
         ref_mem[{15'(idx), 3'(i)}] = v[i*8 +: 8];
   end
endtask

// ------------------------------------------------------------
// Compare tasks
// ------------------------------------------------------------
task automatic check_b(input axi_pkg::axi_b_t got, input axi_pkg::axi_b_t exp);
   if (got !== exp)
      fail_now($sformatf("FAIL b_o got %h expected %h", got, exp));
endtask

task automatic check_r(input axi_pkg::axi_r_t got, input axi_pkg::axi_r_t exp);
   if (got !== exp)
      fail_now($sformatf("FAIL r_o got %h expected %h", got, exp));
endtask

task automatic check_tcdm(input int port, input logic [l2_pkg::DATA_W-1:0] got,
                          input logic [l2_pkg::DATA_W-1:0] exp);
   if (got !== exp)
      fail_now($sformatf("FAIL tcdm_rdata_o[%0d] got %h expected %h", port, got, exp));
endtask

`endif

// File: bench/tb_axi_l2_mem_if.sv
// Testbench of the L2 memory interface with random AXI and TCDM traffic checked against a model
`timescale 1ns/1ps

module tb_axi_l2_mem_if;

   localparam int N_WR  = 80;
   localparam int N_RD  = 80;
   localparam int N_TC  = 70;
   localparam int N_TXN = N_WR + N_RD + 2 * N_TC;
   localparam int LIMIT = N_TXN * 40;

   logic aclk_i;
   logic rst_n_i;
   logic aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
   logic ar_valid_i, ar_ready_o, r_valid_o, r_ready_i;
   axi_pkg::axi_aw_t aw_i;
   axi_pkg::axi_w_t  w_i;
   axi_pkg::axi_b_t  b_o;
   axi_pkg::axi_ar_t ar_i;
   axi_pkg::axi_r_t  r_o;
   logic [1:0] tcdm_req_i, tcdm_gnt_o, tcdm_rvalid_o;
   l2_pkg::l2_req_t [1:0] tcdm_i;
   logic [1:0][l2_pkg::DATA_W-1:0] tcdm_rdata_o;
   l2_pkg::l2_bank_req_t [l2_pkg::NB_BANKS-1:0] bank_o;
   logic [l2_pkg::NB_BANKS-1:0][l2_pkg::DATA_W-1:0] bank_rdata_i;

   logic [l2_pkg::DATA_W-1:0] sram [l2_pkg::NB_BANKS][1 << l2_pkg::ROW_W];
   int cycle_cnt;

   task automatic fail_now(input string what);
      $display("%s", what);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   `include "tb_checks.svh"

   axi_l2_mem_if u_dut
   (
      .aclk_i, .rst_n_i,
      .aw_valid_i, .aw_i, .aw_ready_o, .w_valid_i, .w_i, .w_ready_o,
      .b_valid_o, .b_o, .b_ready_i, .ar_valid_i, .ar_i, .ar_ready_o,
      .r_valid_o, .r_o, .r_ready_i,
      .tcdm_req_i, .tcdm_i, .tcdm_gnt_o, .tcdm_rvalid_o, .tcdm_rdata_o,
      .bank_o, .bank_rdata_i
   );

   initial
   begin
      aclk_i = 1'b0;
      forever #4 aclk_i = ~aclk_i;
   end

   // ------------------------------------------------------------
   // Behavioral SRAM banks on the pins
   // ------------------------------------------------------------
   always @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         bank_rdata_i <= '0;
      else
         for (int b = 0; b < l2_pkg::NB_BANKS; b++)
            if (!bank_o[b].cen)
            begin
               bank_rdata_i[b] <= sram[b][bank_o[b].row];
               if (!bank_o[b].wen)
                  for (int i = 0; i < 8; i++)
                     if (bank_o[b].be[i])
                        sram[b][bank_o[b].row][i*8 +: 8] = bank_o[b].wdata[i*8 +: 8];
            end
   end

   always @(posedge aclk_i)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= LIMIT)
         fail_now("Timeout: the transactions did not complete in time");
   end

   // Upper two bits pick the region of AXI or a TCDM port and the bank bits stay random
   function automatic logic [14:0] pick_word(input int region);
      return {2'(region), 11'($urandom()), 2'($urandom())};
   endfunction

   // ------------------------------------------------------------
   // Stimulus and checks
   // ------------------------------------------------------------
   initial
   begin
      int wr_left, rd_left;
      int tc_left [2];
      int tc_op [2];
      int tc_wait [2];
      logic aw_fire, w_fire, ar_fire, b_wait, rd_wait;
      logic [1:0] tc_busy, tc_rd, tc_gfire, tc_gprev;
      logic [14:0] wr_word, rd_word;
      logic [14:0] tc_word [2];
      logic [63:0] wr_data;
      logic [63:0] tc_exp [2];
      logic [7:0] wr_strb;
      axi_pkg::axi_b_t exp_b;
      axi_pkg::axi_r_t exp_r;
      logic [14:0] written [$];

      void'($urandom(57));
      cycle_cnt = 0;
      rst_n_i = 1'b0;
      {aw_valid_i, w_valid_i, b_ready_i, ar_valid_i, r_ready_i} = '0;
      aw_i = '0;
      w_i = '0;
      ar_i = '0;
      tcdm_req_i = '0;
      tcdm_i = '0;
      bank_rdata_i = '0;
      ref_init();
      for (int b = 0; b < l2_pkg::NB_BANKS; b++)
         for (int r = 0; r < (1 << l2_pkg::ROW_W); r++)
            sram[b][r] = fill_word({13'(r), 2'(b)});
      wr_left = N_WR;
      rd_left = N_RD;
      tc_left = '{N_TC, N_TC};
      tc_op = '{0, 0};
      tc_wait = '{0, 0};
      {aw_fire, w_fire, ar_fire, b_wait, rd_wait} = '0;
      {tc_busy, tc_rd, tc_gfire, tc_gprev} = '0;
      exp_b = '0;
      exp_r = '0;
      repeat (10) @(posedge aclk_i);
      @(negedge aclk_i);
      rst_n_i = 1'b1;

      #1;
      for (int b = 0; b < l2_pkg::NB_BANKS; b++)
         if (!bank_o[b].cen)
            fail_now("A bank is enabled right after reset");
      if (b_valid_o || r_valid_o || tcdm_gnt_o != 2'b00 || tcdm_rvalid_o != 2'b00)
         fail_now("A response or grant is active right after reset");
      if (!aw_ready_o || !w_ready_o || !ar_ready_o)
         fail_now("An AXI ready is low right after reset");

      while (wr_left > 0 || rd_left > 0 || tc_left[0] > 0 || tc_left[1] > 0)
      begin
         @(negedge aclk_i);
         if (aw_fire)
            aw_valid_i = 1'b0;
         if (w_fire)
            w_valid_i = 1'b0;
         if (ar_fire)
            ar_valid_i = 1'b0;
         if (!b_wait && wr_left > 0 && $urandom_range(3) == 0)
         begin
            wr_word = pick_word(0);
            if (!(rd_wait && wr_word == rd_word))
            begin
               wr_data = {$urandom(), $urandom()};
               wr_strb = 8'($urandom());
               // Upper address bits are random to exercise the wrap
               aw_i.id = 16'($urandom());
               aw_i.addr = {14'($urandom()), wr_word, 3'b000};
               w_i.data = wr_data;
               w_i.strb = wr_strb;
               exp_b.id = aw_i.id;
               exp_b.resp = axi_pkg::RESP_OKAY;
               {aw_valid_i, w_valid_i, b_wait} = 3'b111;
            end
         end
         if (!rd_wait && rd_left > 0 && $urandom_range(3) == 0)
         begin
            if (written.size() > 0 && $urandom_range(3) != 0)
               rd_word = written[$urandom_range(written.size() - 1)];
            else
               rd_word = pick_word(0);
            if (!(b_wait && rd_word == wr_word))
            begin
               ar_i.id = 16'($urandom());
               ar_i.addr = {14'($urandom()), rd_word, 3'b000};
               exp_r.id = ar_i.id;
               exp_r.data = ref_word(rd_word);
               exp_r.resp = axi_pkg::RESP_OKAY;
               exp_r.last = 1'b1;
               {ar_valid_i, rd_wait} = 2'b11;
            end
         end
         b_ready_i = ($urandom_range(9) > 3);
         r_ready_i = ($urandom_range(9) > 3);
         for (int p = 0; p < 2; p++)
         begin
            if (tc_gfire[p])
               tcdm_req_i[p] = 1'b0;
            if (!tc_busy[p] && tc_left[p] > 0 && $urandom_range(2) == 0)
            begin
               // Each port writes a word and then reads it back
               tc_rd[p] = tc_op[p][0];
               if (!tc_rd[p])
                  tc_word[p] = pick_word(p + 1);
               tcdm_i[p].wen = tc_rd[p];
               tcdm_i[p].addr.flat = tc_word[p];
               tcdm_i[p].wdata = {$urandom(), $urandom()};
               tcdm_i[p].be = tc_rd[p] ? 8'h00 : 8'($urandom());
               tc_exp[p] = ref_word(tc_word[p]);
               tc_wait[p] = 0;
               tc_busy[p] = 1'b1;
               tcdm_req_i[p] = 1'b1;
            end
         end

         // Sample what the next rising edge will transfer
         #1;
         aw_fire = aw_valid_i && aw_ready_o;
         w_fire = w_valid_i && w_ready_o;
         ar_fire = ar_valid_i && ar_ready_o;
         // A captured channel stays closed until its response is taken
         if (b_wait && ((!aw_valid_i && aw_ready_o) || (!w_valid_i && w_ready_o)))
            fail_now("AW or W is ready again before B was accepted");
         if (rd_wait && !ar_valid_i && ar_ready_o)
            fail_now("AR is ready again before R was accepted");
         if (b_valid_o)
         begin
            if (!b_wait)
               fail_now("B is valid with no write outstanding");
            check_b(b_o, exp_b);
            if (b_ready_i)
            begin
               ref_write(wr_word, wr_data, wr_strb);
               written.push_back(wr_word);
               b_wait = 1'b0;
               wr_left--;
            end
         end
         if (r_valid_o)
         begin
            if (!rd_wait)
               fail_now("R is valid with no read outstanding");
            check_r(r_o, exp_r);
            if (r_ready_i)
            begin
               rd_wait = 1'b0;
               rd_left--;
            end
         end
         for (int p = 0; p < 2; p++)
         begin
            if (tcdm_rvalid_o[p] !== tc_gprev[p])
               fail_now($sformatf("TCDM port %0d rvalid is not one cycle after its grant", p));
            if (tc_gprev[p])
            begin
               if (tc_rd[p])
                  check_tcdm(p, tcdm_rdata_o[p], tc_exp[p]);
               tc_busy[p] = 1'b0;
               tc_left[p]--;
               tc_op[p]++;
            end
            if (tcdm_gnt_o[p] && !tcdm_req_i[p])
               fail_now($sformatf("TCDM port %0d granted without a request", p));
            tc_gfire[p] = tcdm_req_i[p] && tcdm_gnt_o[p];
            if (tc_gfire[p] && !tc_rd[p])
               ref_write(tc_word[p], tcdm_i[p].wdata, tcdm_i[p].be);
            // Round-robin lets at most three other grants go first
            if (tcdm_req_i[p] && !tcdm_gnt_o[p] && !bank_o[tc_word[p][1:0]].cen)
               tc_wait[p]++;
            if (tc_wait[p] > 3)
               fail_now($sformatf("TCDM port %0d waited too long for its bank", p));
         end
         tc_gprev = tc_gfire;
      end

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// File: compile.f
+incdir+bench
verilog/l2_pkg.sv
verilog/axi_pkg.sv
verilog/axi_write_ctrl.sv
verilog/axi_read_ctrl.sv
verilog/l2_bank_arbiter.sv
verilog/l2_xbar.sv
verilog/axi_l2_mem_if.sv
bench/tb_axi_l2_mem_if.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the L2 memory interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_axi_l2_mem_if -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "Simulation ended with status $run_status"
   exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
   echo "No pass line found in sim.log"
   exit 1
fi
exit 0

// File: verilog/axi_l2_mem_if.sv
// L2 memory interface top: AXI slave and two TCDM ports over four SRAM banks
`timescale 1ns/1ps

module axi_l2_mem_if
(
   input  logic                                            aclk_i,
   input  logic                                            rst_n_i,

   // ------------------------------------------------------------
   // AXI slave port
   // ------------------------------------------------------------
   input  logic                                            aw_valid_i,
   input  axi_pkg::axi_aw_t                                aw_i,
   output logic                                            aw_ready_o,
   input  logic                                            w_valid_i,
   input  axi_pkg::axi_w_t                                 w_i,
   output logic                                            w_ready_o,
   output logic                                            b_valid_o,
   output axi_pkg::axi_b_t                                 b_o,
   input  logic                                            b_ready_i,
   input  logic                                            ar_valid_i,
   input  axi_pkg::axi_ar_t                                ar_i,
   output logic                                            ar_ready_o,
   output logic                                            r_valid_o,
   output axi_pkg::axi_r_t                                 r_o,
   input  logic                                            r_ready_i,

   // ------------------------------------------------------------
   // TCDM ports
   // ------------------------------------------------------------
   input  logic            [1:0]                           tcdm_req_i,
   input  l2_pkg::l2_req_t [1:0]                           tcdm_i,
   output logic            [1:0]                           tcdm_gnt_o,
   output logic            [1:0]                           tcdm_rvalid_o,
   output logic [1:0][l2_pkg::DATA_W-1:0]                  tcdm_rdata_o,

   // Bank pins
   output l2_pkg::l2_bank_req_t [l2_pkg::NB_BANKS-1:0]     bank_o,
   input  logic [l2_pkg::NB_BANKS-1:0][l2_pkg::DATA_W-1:0] bank_rdata_i
);

   logic                                         wr_req;
   l2_pkg::l2_req_t                              wr_l2;
   logic                                         rd_req;
   l2_pkg::l2_req_t                              rd_l2;
   logic [l2_pkg::N_REQ-1:0]                     xbar_gnt;
   logic [l2_pkg::N_REQ-1:0]                     xbar_rvalid;
   logic [l2_pkg::N_REQ-1:0][l2_pkg::DATA_W-1:0] xbar_rdata;

   axi_write_ctrl u_write_ctrl
   (
      .aclk_i     ( aclk_i      ),
      .rst_n_i    ( rst_n_i     ),
      .aw_valid_i ( aw_valid_i  ),
      .aw_i       ( aw_i        ),
      .aw_ready_o ( aw_ready_o  ),
      .w_valid_i  ( w_valid_i   ),
      .w_i        ( w_i         ),
      .w_ready_o  ( w_ready_o   ),
      .b_valid_o  ( b_valid_o   ),
      .b_o        ( b_o         ),
      .b_ready_i  ( b_ready_i   ),
      .l2_req_o   ( wr_req      ),
      .l2_o       ( wr_l2       ),
      .l2_gnt_i   ( xbar_gnt[0] )
   );

   axi_read_ctrl u_read_ctrl
   (
      .aclk_i      ( aclk_i         ),
      .rst_n_i     ( rst_n_i        ),
      .ar_valid_i  ( ar_valid_i     ),
      .ar_i        ( ar_i           ),
      .ar_ready_o  ( ar_ready_o     ),
      .r_valid_o   ( r_valid_o      ),
      .r_o         ( r_o            ),
      .r_ready_i   ( r_ready_i      ),
      .l2_req_o    ( rd_req         ),
      .l2_o        ( rd_l2          ),
      .l2_gnt_i    ( xbar_gnt[1]    ),
      .l2_rvalid_i ( xbar_rvalid[1] ),
      .l2_rdata_i  ( xbar_rdata[1]  )
   );

   // Requester order: AXI write, AXI read, TCDM 0, TCDM 1
   l2_xbar u_xbar
   (
      .aclk_i       ( aclk_i                          ),
      .rst_n_i      ( rst_n_i                         ),
      .req_i        ( {tcdm_req_i, rd_req, wr_req}    ),
      .l2_i         ( {tcdm_i, rd_l2, wr_l2}          ),
      .gnt_o        ( xbar_gnt                        ),
      .rvalid_o     ( xbar_rvalid                     ),
      .rdata_o      ( xbar_rdata                      ),
      .bank_o       ( bank_o                          ),
      .bank_rdata_i ( bank_rdata_i                    )
   );

   assign tcdm_gnt_o    = xbar_gnt[l2_pkg::N_REQ-1:2];
   assign tcdm_rvalid_o = xbar_rvalid[l2_pkg::N_REQ-1:2];
   assign tcdm_rdata_o  = xbar_rdata[l2_pkg::N_REQ-1:2];

endmodule

// File: verilog/axi_pkg.sv
// AXI side definitions: field widths, response code and channel payloads
package axi_pkg;

   // ------------------------------------------------------------
   // Field widths and codes
   // ------------------------------------------------------------
   localparam int         ID_W      = 16;
   localparam int         ADDR_W    = 32;
   localparam logic [1:0] RESP_OKAY = 2'b00;

   // Write address channel
   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [ADDR_W-1:0] addr;
   } axi_aw_t;

   // Write data channel, single beat
   typedef struct packed {
      logic [l2_pkg::DATA_W-1:0] data;
      logic [l2_pkg::BE_W-1:0]   strb;
   } axi_w_t;

   // Write response channel
   typedef struct packed {
      logic [ID_W-1:0] id;
      logic [1:0]      resp;
   } axi_b_t;

   // Read address channel
   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [ADDR_W-1:0] addr;
   } axi_ar_t;

   // Read data channel
   typedef struct packed {
      logic [ID_W-1:0]           id;
      logic [l2_pkg::DATA_W-1:0] data;
      logic [1:0]                resp;
      logic                      last;
   } axi_r_t;

endpackage

// File: verilog/axi_read_ctrl.sv
// AXI read controller: accepts one AR, reads L2 and holds the R beat until taken
`timescale 1ns/1ps

module axi_read_ctrl
(
   input  logic                      aclk_i,
   input  logic                      rst_n_i,

   input  logic                      ar_valid_i,
   input  axi_pkg::axi_ar_t          ar_i,
   output logic                      ar_ready_o,

   output logic                      r_valid_o,
   output axi_pkg::axi_r_t           r_o,
   input  logic                      r_ready_i,

   output logic                      l2_req_o,
   output l2_pkg::l2_req_t           l2_o,
   input  logic                      l2_gnt_i,
   input  logic                      l2_rvalid_i,
   input  logic [l2_pkg::DATA_W-1:0] l2_rdata_i
);

   logic                      busy_q;
   logic                      req_q;
   logic                      r_hold_q;
   axi_pkg::axi_ar_t          ar_q;
   logic [l2_pkg::DATA_W-1:0] rdata_q;

   logic                      ar_hs;
   logic                      r_done;

   assign ar_ready_o = ~busy_q;
   assign ar_hs      = ar_valid_i & ar_ready_o;
   assign r_done     = r_valid_o & r_ready_i;

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         busy_q   <= 1'b0;
         req_q    <= 1'b0;
         r_hold_q <= 1'b0;
      end
      else
      begin
         // AR stays closed until the R beat is accepted
         if (ar_hs)
            busy_q <= 1'b1;
         else if (r_done)
            busy_q <= 1'b0;

         if (ar_hs)
            req_q <= 1'b1;
         else if (l2_gnt_i)
            req_q <= 1'b0;

         if (l2_rvalid_i && !r_ready_i)
            r_hold_q <= 1'b1;
         else if (r_done)
            r_hold_q <= 1'b0;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (ar_hs)
         ar_q <= ar_i;
      if (l2_rvalid_i)
         rdata_q <= l2_rdata_i;
   end

   // ------------------------------------------------------------
   // L2 read request
   // ------------------------------------------------------------
   assign l2_req_o       = req_q;
   assign l2_o.wen       = 1'b1;
   assign l2_o.addr.flat = ar_q.addr[l2_pkg::OFFSET_W +: l2_pkg::WORD_ADDR_W];
   assign l2_o.wdata     = '0;
   assign l2_o.be        = '0;

   // R is offered straight from rvalid, then from the holding register
   assign r_valid_o = l2_rvalid_i | r_hold_q;
   assign r_o.id    = ar_q.id;
   assign r_o.data  = r_hold_q ? rdata_q : l2_rdata_i;
   assign r_o.resp  = axi_pkg::RESP_OKAY;
   assign r_o.last  = 1'b1;

endmodule

// File: verilog/axi_write_ctrl.sv
// AXI write controller: captures one AW and one W beat, writes L2 and returns B
`timescale 1ns/1ps

module axi_write_ctrl
(
   input  logic               aclk_i,
   input  logic               rst_n_i,

   input  logic               aw_valid_i,
   input  axi_pkg::axi_aw_t   aw_i,
   output logic               aw_ready_o,

   input  logic               w_valid_i,
   input  axi_pkg::axi_w_t    w_i,
   output logic               w_ready_o,

   output logic               b_valid_o,
   output axi_pkg::axi_b_t    b_o,
   input  logic               b_ready_i,

   output logic               l2_req_o,
   output l2_pkg::l2_req_t    l2_o,
   input  logic               l2_gnt_i
);

   logic             aw_held_q;
   logic             w_held_q;
   logic             req_q;
   logic             b_valid_q;
   axi_pkg::axi_aw_t aw_q;
   axi_pkg::axi_w_t  w_q;

   logic             aw_hs;
   logic             w_hs;
   logic             launch;
   logic             b_done;

   // ------------------------------------------------------------
   // Handshakes
   // ------------------------------------------------------------
   // A channel stays closed from its capture until B is taken
   assign aw_ready_o = ~aw_held_q;
   assign w_ready_o  = ~w_held_q;

   assign aw_hs  = aw_valid_i & aw_ready_o;
   assign w_hs   = w_valid_i & w_ready_o;
   assign b_done = b_valid_q & b_ready_i;

   // Both phases present and no write in flight yet
   assign launch = (aw_held_q | aw_hs) & (w_held_q | w_hs) & ~req_q & ~b_valid_q;

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         aw_held_q <= 1'b0;
         w_held_q  <= 1'b0;
         req_q     <= 1'b0;
         b_valid_q <= 1'b0;
      end
      else
      begin
         if (b_done)
            aw_held_q <= 1'b0;
         else if (aw_hs)
            aw_held_q <= 1'b1;

         if (b_done)
            w_held_q <= 1'b0;
         else if (w_hs)
            w_held_q <= 1'b1;

         if (launch)
            req_q <= 1'b1;
         else if (l2_gnt_i)
            req_q <= 1'b0;

         // B follows the grant by one cycle
         if (req_q && l2_gnt_i)
            b_valid_q <= 1'b1;
         else if (b_ready_i)
            b_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (aw_hs)
         aw_q <= aw_i;
      if (w_hs)
         w_q <= w_i;
   end

   // ------------------------------------------------------------
   // L2 request and B payload
   // ------------------------------------------------------------
   assign l2_req_o = req_q;

   always_comb
   begin
      l2_o.wen       = 1'b0;
      l2_o.addr.flat = aw_q.addr[l2_pkg::OFFSET_W +: l2_pkg::WORD_ADDR_W];
      l2_o.wdata     = w_q.data;
      l2_o.be        = w_q.strb;
   end

   assign b_valid_o = b_valid_q;
   assign b_o.id    = aw_q.id;
   assign b_o.resp  = axi_pkg::RESP_OKAY;

endmodule

// File: verilog/l2_bank_arbiter.sv
// Round-robin arbiter granting one requester per cycle on a single L2 bank
`timescale 1ns/1ps

module l2_bank_arbiter
(
   input  logic                           aclk_i,
   input  logic                           rst_n_i,

   input  logic [l2_pkg::N_REQ-1:0]       req_i,
   output logic [l2_pkg::N_REQ-1:0]       gnt_o,
   output logic [l2_pkg::REQ_IDX_W-1:0]   winner_o
);

   // Requester with the highest priority in the current cycle
   logic [l2_pkg::REQ_IDX_W-1:0] ptr_q;

   logic [l2_pkg::REQ_IDX_W-1:0] cand;
   logic                         found;

   // ------------------------------------------------------------
   // Search from the pointer upwards, wrapping at N_REQ
   // ------------------------------------------------------------
   always_comb
   begin
      gnt_o    = '0;
      winner_o = ptr_q;
      found    = 1'b0;
      cand     = ptr_q;
      for (int k = 0; k < l2_pkg::N_REQ; k++)
      begin
         cand = ptr_q + l2_pkg::REQ_IDX_W'(k);
         if (!found && req_i[cand])
         begin
            found       = 1'b1;
            winner_o    = cand;
            gnt_o[cand] = 1'b1;
         end
      end
   end

   // ------------------------------------------------------------
   // Pointer update
   // ------------------------------------------------------------
   // Moves past the winner, so the winner drops to lowest priority
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         ptr_q <= '0;
      else if (found)
         ptr_q <= winner_o + 1'b1;
   end

endmodule

// File: verilog/l2_pkg.sv
// L2 side definitions: bank geometry, word address decoding and request structs
package l2_pkg;

   // ------------------------------------------------------------
   // Bank geometry
   // ------------------------------------------------------------
   localparam int NB_BANKS    = 4;
   localparam int BANK_SEL_W  = 2;
   localparam int ROW_W       = 13;
   localparam int WORD_ADDR_W = ROW_W + BANK_SEL_W;

   // Data path, one 64-bit word per bank row
   localparam int DATA_W      = 64;
   localparam int BE_W        = DATA_W / 8;
   localparam int OFFSET_W    = 3;

   // Crossbar requesters: 0 AXI write, 1 AXI read, 2..3 TCDM
   localparam int N_REQ       = 4;
   localparam int REQ_IDX_W   = 2;

   // ------------------------------------------------------------
   // Word address, seen flat or as row/bank
   // ------------------------------------------------------------
   // Word interleaving puts the bank select in the low bits
   typedef union packed {
      logic [WORD_ADDR_W-1:0] flat;
      struct packed {
         logic [ROW_W-1:0]      row;
         logic [BANK_SEL_W-1:0] bank;
      } rb;
   } l2_word_addr_u;

   // One requester towards the crossbar
   typedef struct packed {
      logic                wen;    // High for read
      l2_word_addr_u       addr;
      logic [DATA_W-1:0]   wdata;
      logic [BE_W-1:0]     be;
   } l2_req_t;

   // One bank's SRAM pins
   typedef struct packed {
      logic                cen;    // Active low
      logic                wen;    // Active low write
      logic [ROW_W-1:0]    row;
      logic [DATA_W-1:0]   wdata;
      logic [BE_W-1:0]     be;
   } l2_bank_req_t;

endpackage

// File: verilog/l2_xbar.sv
// L2 crossbar: bank decode, per-bank round-robin and read data return
`timescale 1ns/1ps

module l2_xbar
(
   input  logic                                            aclk_i,
   input  logic                                            rst_n_i,

   input  logic            [l2_pkg::N_REQ-1:0]             req_i,
   input  l2_pkg::l2_req_t [l2_pkg::N_REQ-1:0]             l2_i,
   output logic            [l2_pkg::N_REQ-1:0]             gnt_o,
   output logic            [l2_pkg::N_REQ-1:0]             rvalid_o,
   output logic [l2_pkg::N_REQ-1:0][l2_pkg::DATA_W-1:0]    rdata_o,

   output l2_pkg::l2_bank_req_t [l2_pkg::NB_BANKS-1:0]     bank_o,
   input  logic [l2_pkg::NB_BANKS-1:0][l2_pkg::DATA_W-1:0] bank_rdata_i
);

   logic [l2_pkg::NB_BANKS-1:0][l2_pkg::N_REQ-1:0]     bank_req;
   logic [l2_pkg::NB_BANKS-1:0][l2_pkg::N_REQ-1:0]     bank_gnt;
   logic [l2_pkg::NB_BANKS-1:0][l2_pkg::REQ_IDX_W-1:0] bank_winner;

   // Per requester: granted last cycle, and on which bank
   logic [l2_pkg::N_REQ-1:0]                           gnt_q;
   logic [l2_pkg::N_REQ-1:0][l2_pkg::BANK_SEL_W-1:0]   bank_sel_q;

   // ------------------------------------------------------------
   // Per bank request decode, arbitration and pin drive
   // ------------------------------------------------------------
   for (genvar b = 0; b < l2_pkg::NB_BANKS; b++)
   begin : g_bank
      for (genvar r = 0; r < l2_pkg::N_REQ; r++)
      begin : g_req
         assign bank_req[b][r] = req_i[r] &
                                 (l2_i[r].addr.rb.bank == l2_pkg::BANK_SEL_W'(b));
      end

      l2_bank_arbiter u_arb
      (
         .aclk_i   ( aclk_i         ),
         .rst_n_i  ( rst_n_i        ),
         .req_i    ( bank_req[b]    ),
         .gnt_o    ( bank_gnt[b]    ),
         .winner_o ( bank_winner[b] )
      );

      assign bank_o[b].cen   = ~(|bank_req[b]);
      assign bank_o[b].wen   = l2_i[bank_winner[b]].wen;
      assign bank_o[b].row   = l2_i[bank_winner[b]].addr.rb.row;
      assign bank_o[b].wdata = l2_i[bank_winner[b]].wdata;
      assign bank_o[b].be    = l2_i[bank_winner[b]].be;
   end

   // A requester targets one bank only, so at most one term is set
   always_comb
   begin
      gnt_o = '0;
      for (int k = 0; k < l2_pkg::NB_BANKS; k++)
         gnt_o = gnt_o | bank_gnt[k];
   end

   // ------------------------------------------------------------
   // Response path, one cycle after the grant
   // ------------------------------------------------------------
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         gnt_q <= '0;
      else
         gnt_q <= gnt_o;
   end

   always_ff @(posedge aclk_i)
   begin
      for (int r = 0; r < l2_pkg::N_REQ; r++)
         if (gnt_o[r])
            bank_sel_q[r] <= l2_i[r].addr.rb.bank;
   end

   assign rvalid_o = gnt_q;

   always_comb
   begin
      for (int r = 0; r < l2_pkg::N_REQ; r++)
         rdata_o[r] = bank_rdata_i[bank_sel_q[r]];
   end

endmodule
